// File: include/ahbl_params.svh
/*
 * AHB-lite fabric configuration macros
 * Port count, bus widths, address map and decode masks, SRAM size, wait states
 */

`ifndef AHBL_PARAMS_SVH
`define AHBL_PARAMS_SVH

// Two slave windows behind the splitter
`define AHBL_N_PORTS    2
`define AHBL_W_ADDR     32
`define AHBL_W_DATA     32

// Port 0 in the low word, port 1 in the high word
`define AHBL_ADDR_MAP   64'h30000000_20000000
`define AHBL_ADDR_MASK  64'hf0000000_f0000000

// Per-slave SRAM size and data-phase wait states
`define AHBL_SRAM_BYTES 256
`define AHBL_WAIT_S0    0
`define AHBL_WAIT_S1    2

`endif

// File: design/ahbl_pkg.sv
/*
 * AHB-lite shared types
 * HTRANS, HSIZE and HRESP encodings, address-phase request and data-phase response structs
 */

`include "ahbl_params.svh"

package ahbl_pkg;

	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	// Only up to bus width on a 32-bit fabric
	typedef enum logic [2:0] {
		BYTE = 3'b000,
		HALF = 3'b001,
		WORD = 3'b010
	} hsize_e;

	typedef enum logic {
		OKAY  = 1'b0,
		ERROR = 1'b1
	} hresp_e;

	// Everything the master presents in the address phase
	typedef struct packed {
		logic [`AHBL_W_ADDR-1:0] haddr;
		logic                    hwrite;
		htrans_e                 htrans;
		hsize_e                  hsize;
		logic [2:0]              hburst;
		logic [3:0]              hprot;
		logic                    hmastlock;
	} ahbl_req_t;

	// Slave result for one data phase
	typedef struct packed {
		hresp_e                  hresp;
		logic [`AHBL_W_DATA-1:0] hrdata;
	} ahbl_dresp_t;

endpackage

// File: design/bitmap_mux.sv
/*
 * One-hot OR multiplexer
 * Payload type is a parameter, result is zero when no select bit is set
 */

module bitmap_mux #(
	parameter int  N_INPUTS  = 2,
	parameter type payload_t = logic
) (
	input  payload_t            in [N_INPUTS],
	input  logic [N_INPUTS-1:0] sel,
	output payload_t            out
);

	// OR of all selected inputs
	// Select is expected one-hot or empty, so no priority is needed
	always_comb begin
		out = '0;
		for (int i = 0; i < N_INPUTS; i++) begin
			if (sel[i]) begin
				out = payload_t'(out | in[i]);
			end
		end
	end

endmodule

// File: design/ahbl_splitter.sv
/*
 * AHB-lite 1:N splitter
 * Address decode by mask and match, per-port HTRANS gating,
 * data-phase select register and one-hot response return
 */

`include "ahbl_params.svh"

module ahbl_splitter #(
	parameter int                                N_PORTS   = `AHBL_N_PORTS,
	parameter logic [N_PORTS*`AHBL_W_ADDR-1:0] ADDR_MAP  = `AHBL_ADDR_MAP,
	parameter logic [N_PORTS*`AHBL_W_ADDR-1:0] ADDR_MASK = `AHBL_ADDR_MASK
) (
	input  logic                    clk,
	input  logic                    rst_n,

	// Master side
	input  logic                    hready,
	output logic                    hready_resp,
	input  ahbl_pkg::ahbl_req_t     req,
	input  logic [`AHBL_W_DATA-1:0] hwdata,
	output ahbl_pkg::ahbl_dresp_t   dresp,

	// Slave side
	output ahbl_pkg::ahbl_req_t     s_req [N_PORTS],
	output logic [N_PORTS-1:0]      s_hready,
	output logic [`AHBL_W_DATA-1:0] s_hwdata [N_PORTS],
	input  logic [N_PORTS-1:0]      s_hready_resp,
	input  ahbl_pkg::ahbl_dresp_t   s_dresp [N_PORTS]
);

	localparam int W_ADDR = `AHBL_W_ADDR;

	logic [N_PORTS-1:0] sel_aph;
	logic [N_PORTS-1:0] sel_dph;
	logic [N_PORTS-1:0] rdy_sel;
	logic               rdy_in [N_PORTS];
	logic               rdy_mux;

	// Decode and request fan-out
	// Windows must not overlap, so at most one bit of sel_aph is set
	always_comb begin
		for (int i = 0; i < N_PORTS; i++) begin
			sel_aph[i] = ~|((req.haddr ^ ADDR_MAP[i*W_ADDR +: W_ADDR])
				& ADDR_MASK[i*W_ADDR +: W_ADDR]);
			s_req[i] = req;
			// Unselected ports only ever see IDLE
			if (!sel_aph[i]) begin
				s_req[i].htrans = ahbl_pkg::IDLE;
			end
		end
	end

	// Data-phase signals go to every port
	assign s_hready = {N_PORTS{hready}};

	always_comb begin
		for (int i = 0; i < N_PORTS; i++) begin
			s_hwdata[i] = hwdata;
			rdy_in[i]   = s_hready_resp[i];
		end
	end

	// Owner of the current data phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_dph <= '0;
		end else if (hready) begin
			sel_dph <= sel_aph;
		end
	end

	// Read data and response from the data-phase owner only
	bitmap_mux #(
		.N_INPUTS  (N_PORTS),
		.payload_t (ahbl_pkg::ahbl_dresp_t)
	) u_dresp_mux (
		.in  (s_dresp),
		.sel (sel_dph),
		.out (dresp)
	);

	// Ready follows the data-phase owner, else the port being addressed
	assign rdy_sel = (|sel_dph) ? sel_dph : sel_aph;

	bitmap_mux #(
		.N_INPUTS  (N_PORTS),
		.payload_t (logic)
	) u_ready_mux (
		.in  (rdy_in),
		.sel (rdy_sel),
		.out (rdy_mux)
	);

	// Nothing owned and nothing addressed, bus stays ready
	assign hready_resp = (|rdy_sel) ? rdy_mux : 1'b1;

endmodule

// File: design/ahbl_sram_slave.sv
/*
 * AHB-lite SRAM slave
 * Little-endian byte lanes, N_WAIT data-phase wait states,
 * two-cycle ERROR on unaligned transfers
 */

`include "ahbl_params.svh"

module ahbl_sram_slave #(
	parameter int N_WAIT      = 0,
	parameter int DEPTH_BYTES = `AHBL_SRAM_BYTES
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  ahbl_pkg::ahbl_req_t     req,
	input  logic                    hready,
	input  logic [`AHBL_W_DATA-1:0] hwdata,
	output logic                    hready_resp,
	output ahbl_pkg::ahbl_dresp_t   dresp
);

	localparam int N_WORDS = DEPTH_BYTES / 4;
	localparam int W_IDX   = $clog2(N_WORDS);
	localparam int W_CNT   = (N_WAIT > 0) ? $clog2(N_WAIT + 1) : 1;

	logic [`AHBL_W_DATA-1:0] mem [N_WORDS];

	logic             aph_valid;
	logic             aph_bad;
	logic             dph_active;
	logic             dph_err;
	logic             err_second;
	logic [W_CNT-1:0] wait_cnt;
	logic             dph_write;
	ahbl_pkg::hsize_e dph_size;
	logic [W_IDX+1:0] dph_addr;
	logic [3:0]       lanes;
	logic             mem_we;

	// Accepted transfer this edge
	assign aph_valid = hready &&
		(req.htrans == ahbl_pkg::NONSEQ || req.htrans == ahbl_pkg::SEQ);

	// Alignment check, sizes above WORD are illegal on this bus
	always_comb begin
		case (req.hsize)
			ahbl_pkg::BYTE: aph_bad = 1'b0;
			ahbl_pkg::HALF: aph_bad = req.haddr[0];
			ahbl_pkg::WORD: aph_bad = |req.haddr[1:0];
			default:        aph_bad = 1'b1;
		endcase
	end

	// Data-phase control
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_active <= 1'b0;
			dph_err    <= 1'b0;
			err_second <= 1'b0;
			wait_cnt   <= '0;
		end else if (hready) begin
			dph_active <= aph_valid;
			dph_err    <= aph_valid && aph_bad;
			err_second <= 1'b0;
			wait_cnt   <= W_CNT'(N_WAIT);
		end else if (dph_active) begin
			// Error runs its own two cycles, no wait states
			if (dph_err) begin
				err_second <= 1'b1;
			end else if (wait_cnt != '0) begin
				wait_cnt <= wait_cnt - 1'b1;
			end
		end
	end

	// Address-phase capture
	always_ff @(posedge clk) begin
		if (aph_valid) begin
			dph_write <= req.hwrite;
			dph_size  <= req.hsize;
			dph_addr  <= req.haddr[W_IDX+1:0];
		end
	end

	// Byte lanes of the data-phase transfer
	always_comb begin
		case (dph_size)
			ahbl_pkg::BYTE: lanes = 4'b0001 << dph_addr[1:0];
			ahbl_pkg::HALF: lanes = 4'b0011 << {dph_addr[1], 1'b0};
			default:        lanes = 4'b1111;
		endcase
	end

	// Write lands on the edge that ends the data phase
	assign mem_we = hready && dph_active && dph_write && !dph_err;

	always_ff @(posedge clk) begin
		if (mem_we) begin
			for (int b = 0; b < 4; b++) begin
				if (lanes[b]) begin
					mem[dph_addr[W_IDX+1:2]][8*b +: 8] <= hwdata[8*b +: 8];
				end
			end
		end
	end

	// Ready low while waiting, or in the first ERROR cycle
	assign hready_resp = !dph_active ? 1'b1 :
		dph_err ? err_second : (wait_cnt == '0);

	assign dresp.hresp  = (dph_active && dph_err) ? ahbl_pkg::ERROR : ahbl_pkg::OKAY;
	// Whole word, master picks its lanes
	assign dresp.hrdata = (dph_active && !dph_write && !dph_err) ?
		mem[dph_addr[W_IDX+1:2]] : '0;

endmodule

// File: design/ahbl_fabric_top.sv
/*
 * AHB-lite fabric top level
 * Splitter at the top of the fabric driving a fast and a slow SRAM slave
 */

`include "ahbl_params.svh"

module ahbl_fabric_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  ahbl_pkg::ahbl_req_t     req,
	input  logic [`AHBL_W_DATA-1:0] hwdata,
	output logic                    hready,
	output ahbl_pkg::ahbl_dresp_t   dresp
);

	ahbl_pkg::ahbl_req_t     s_req [`AHBL_N_PORTS];
	logic [`AHBL_N_PORTS-1:0] s_hready;
	logic [`AHBL_W_DATA-1:0] s_hwdata [`AHBL_N_PORTS];
	logic [`AHBL_N_PORTS-1:0] s_hready_resp;
	ahbl_pkg::ahbl_dresp_t   s_dresp [`AHBL_N_PORTS];

	// No master above the splitter, so ready response loops back as hready
	ahbl_splitter u_splitter (
		.clk           (clk),
		.rst_n         (rst_n),
		.hready        (hready),
		.hready_resp   (hready),
		.req           (req),
		.hwdata        (hwdata),
		.dresp         (dresp),
		.s_req         (s_req),
		.s_hready      (s_hready),
		.s_hwdata      (s_hwdata),
		.s_hready_resp (s_hready_resp),
		.s_dresp       (s_dresp)
	);

	// Window 0, zero wait states
	ahbl_sram_slave #(
		.N_WAIT      (`AHBL_WAIT_S0),
		.DEPTH_BYTES (`AHBL_SRAM_BYTES)
	) u_sram0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (s_req[0]),
		.hready      (s_hready[0]),
		.hwdata      (s_hwdata[0]),
		.hready_resp (s_hready_resp[0]),
		.dresp       (s_dresp[0])
	);

	// Window 1, slow slave
	ahbl_sram_slave #(
		.N_WAIT      (`AHBL_WAIT_S1),
		.DEPTH_BYTES (`AHBL_SRAM_BYTES)
	) u_sram1 (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (s_req[1]),
		.hready      (s_hready[1]),
		.hwdata      (s_hwdata[1]),
		.hready_resp (s_hready_resp[1]),
		.dresp       (s_dresp[1])
	);

endmodule

// File: dv/ahbl_fabric_assert.sv
/*
 * Protocol assertions for the AHB-lite splitter
 * Single active slave request, one-hot data-phase select, two-cycle ERROR
 */

module ahbl_fabric_assert #(
	parameter int N_PORTS = 2
) (
	input logic                  clk,
	input logic                  rst_n,
	input ahbl_pkg::ahbl_req_t   s_req [N_PORTS],
	input logic [N_PORTS-1:0]    sel_dph,
	input logic                  hready_resp,
	input ahbl_pkg::ahbl_dresp_t dresp
);

	logic [N_PORTS-1:0] active;

	// Ports currently handed a real transfer
	always_comb begin
		for (int i = 0; i < N_PORTS; i++) begin
			active[i] = (s_req[i].htrans == ahbl_pkg::NONSEQ) ||
				(s_req[i].htrans == ahbl_pkg::SEQ);
		end
	end

	// Decode never hands a transfer to two slaves
	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(active))
		else $error("more than one slave sees an active htrans");

	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(sel_dph))
		else $error("data-phase select has more than one bit set");

	// Ready-high ERROR cycle only after a ready-low ERROR cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		(dresp.hresp == ahbl_pkg::ERROR && hready_resp) |->
		$past(dresp.hresp == ahbl_pkg::ERROR && !hready_resp))
		else $error("ERROR response without a first cycle of hready_resp low");

endmodule

bind ahbl_splitter ahbl_fabric_assert #(.N_PORTS(N_PORTS)) u_assert (
	.clk         (clk),
	.rst_n       (rst_n),
	.s_req       (s_req),
	.sel_dph     (sel_dph),
	.hready_resp (hready_resp),
	.dresp       (dresp)
);

// File: dv/ahbl_fabric_tb.sv
/*
 * AHB-lite fabric testbench
 * LFSR stimulus, pipelined master, byte memory model, compare tasks, watchdog
 */

`include "ahbl_params.svh"

module ahbl_fabric_tb;

	localparam int N_RANDOM = 200;
	localparam int N_WORDS  = `AHBL_SRAM_BYTES / 4;
	// Fill writes, read-back and up to two transfers per random item
	localparam int MAX_XFERS = 4 * N_WORDS + 2 * N_RANDOM;
	localparam logic [2*`AHBL_W_ADDR-1:0] ADDR_MAP = `AHBL_ADDR_MAP;

	typedef struct packed {
		logic                    port;
		logic [7:0]              off;
		ahbl_pkg::hsize_e        size;
		logic                    write;
		logic [`AHBL_W_DATA-1:0] data;
	} xfer_t;

	logic                    clk = 1'b0;
	logic                    rst_n;
	ahbl_pkg::ahbl_req_t     req;
	logic [`AHBL_W_DATA-1:0] hwdata;
	logic                    hready;
	ahbl_pkg::ahbl_dresp_t   dresp;

	logic [15:0] lfsr = 16'd42962;
	logic [7:0]  model [2][`AHBL_SRAM_BYTES];
	xfer_t       xfer_q [$];

	ahbl_fabric_top dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (req),
		.hwdata (hwdata),
		.hready (hready),
		.dresp  (dresp)
	);

	always #50 clk = ~clk;

	// Galois LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
		end
		return r;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_rdata(input logic [`AHBL_W_DATA-1:0] got,
			input logic [`AHBL_W_DATA-1:0] exp, input string what);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t: %s hrdata %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_resp(input ahbl_pkg::hresp_e got, input ahbl_pkg::hresp_e exp);
		if (got !== exp) begin
			fail_run($sformatf("mismatch at %0t: hresp %0d, expected %0d", $time, got, exp));
		end
	endtask

	task automatic check_wait(input int got, input int exp);
		if (got != exp) begin
			fail_run($sformatf("mismatch at %0t: %0d hready-low cycles, expected %0d",
				$time, got, exp));
		end
	endtask

	function automatic logic [`AHBL_W_ADDR-1:0] full_addr(input logic port, input logic [7:0] off);
		return ADDR_MAP[int'(port) * `AHBL_W_ADDR +: `AHBL_W_ADDR] | 32'(off);
	endfunction

	// Fill value built from every address bit
	function automatic logic [31:0] fill_word(input logic port, input logic [7:0] off);
		logic [31:0] a;
		a = full_addr(port, off);
		return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
	endfunction

	function automatic logic is_unaligned(input xfer_t x);
		return (x.size == ahbl_pkg::HALF && x.off[0]) ||
			(x.size == ahbl_pkg::WORD && x.off[1:0] != 2'b00);
	endfunction

	// Little-endian lanes of an aligned access
	function automatic logic [3:0] lane_mask(input xfer_t x);
		case (x.size)
			ahbl_pkg::BYTE: return 4'b0001 << x.off[1:0];
			ahbl_pkg::HALF: return 4'b0011 << x.off[1:0];
			default:        return 4'b1111;
		endcase
	endfunction

	task automatic add_xfer(input logic port, input logic [7:0] off, input ahbl_pkg::hsize_e size,
			input logic write, input logic [31:0] data);
		xfer_t x;
		x.port  = port;
		x.off   = off;
		x.size  = size;
		x.write = write;
		x.data  = data;
		xfer_q.push_back(x);
	endtask

	task automatic add_random();
		xfer_t x;
		x.port = 1'(rand_bits(1));
		x.off  = 8'(rand_bits(8));
		case (2'(rand_bits(2)))
			2'd0:    x.size = ahbl_pkg::BYTE;
			2'd1:    x.size = ahbl_pkg::HALF;
			default: x.size = ahbl_pkg::WORD;
		endcase
		x.write = 1'(rand_bits(1));
		x.data  = rand_bits(32);
		// One in four keeps its raw offset and may be unaligned
		if (2'(rand_bits(2)) != 2'd0) begin
			if (x.size == ahbl_pkg::HALF) x.off[0] = 1'b0;
			if (x.size == ahbl_pkg::WORD) x.off[1:0] = 2'b00;
		end
		xfer_q.push_back(x);
		// Word read-back after sub-word writes and errors
		if ((x.write && x.size != ahbl_pkg::WORD) || is_unaligned(x)) begin
			add_xfer(x.port, {x.off[7:2], 2'b00}, ahbl_pkg::WORD, 1'b0, '0);
		end
	endtask

	task automatic drive_aph(input logic valid, input xfer_t x);
		req       = '0;
		req.hprot = 4'b0011;
		if (valid) begin
			req.haddr  = full_addr(x.port, x.off);
			req.hwrite = x.write;
			req.htrans = ahbl_pkg::NONSEQ;
			req.hsize  = x.size;
		end
	endtask

	// Completed data phase, model update or read compare
	task automatic finish_dph(input xfer_t x);
		logic [31:0] word;
		logic [31:0] mask;
		logic [7:0]  base;
		logic [3:0]  lanes;
		base  = {x.off[7:2], 2'b00};
		lanes = lane_mask(x);
		for (int b = 0; b < 4; b++) begin
			word[8*b +: 8] = model[x.port][8'(base + b)];
			mask[8*b +: 8] = {8{lanes[b]}};
		end
		if (!is_unaligned(x)) begin
			if (x.write) begin
				for (int b = 0; b < 4; b++) begin
					if (lanes[b]) model[x.port][8'(base + b)] = x.data[8*b +: 8];
				end
			end else begin
				check_rdata(dresp.hrdata & mask, word & mask,
					$sformatf("read port %0d offset %h", x.port, x.off));
			end
		end
	endtask

	// Pipelined master, outputs sampled at the falling edge
	task automatic run_transfers();
		xfer_t             aph;
		xfer_t             dph;
		logic              aph_v;
		logic              dph_v;
		int                waits;
		ahbl_pkg::hresp_e  exp_resp;
		dph_v = 1'b0;
		waits = 0;
		aph_v = xfer_q.size() > 0;
		if (aph_v) aph = xfer_q.pop_front();
		drive_aph(aph_v, aph);
		while (aph_v || dph_v) begin
			@(negedge clk);
			if (dph_v) begin
				exp_resp = ahbl_pkg::OKAY;
				if (is_unaligned(dph)) exp_resp = ahbl_pkg::ERROR;
				check_resp(dresp.hresp, exp_resp);
				if (!hready) begin
					waits++;
				end else begin
					check_wait(waits, is_unaligned(dph) ? 1 :
						(dph.port ? `AHBL_WAIT_S1 : `AHBL_WAIT_S0));
					finish_dph(dph);
					waits = 0;
				end
			end
			// Address phase accepted, move it to the data phase
			if (hready) begin
				dph   = aph;
				dph_v = aph_v;
				aph_v = xfer_q.size() > 0;
				if (aph_v) aph = xfer_q.pop_front();
			end
			@(posedge clk);
			#1;
			drive_aph(aph_v, aph);
			hwdata = (dph_v && dph.write) ? dph.data : '0;
		end
	endtask

	initial begin
		#((MAX_XFERS * 10 + 100) * 100);
		fail_run("Watchdog expired before all transfers completed");
	end

	initial begin
		rst_n  = 1'b0;
		req    = '0;
		hwdata = '0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		if (hready !== 1'b1) fail_run("hready is not high after reset");
		check_resp(dresp.hresp, ahbl_pkg::OKAY);
		@(posedge clk);
		#1;
		// Fill both windows, alternating slaves, then read everything back
		for (int w = 0; w < N_WORDS; w++) begin
			for (int p = 0; p < 2; p++) begin
				add_xfer(1'(p), 8'(w * 4), ahbl_pkg::WORD, 1'b1, fill_word(1'(p), 8'(w * 4)));
			end
		end
		for (int w = 0; w < N_WORDS; w++) begin
			for (int p = 0; p < 2; p++) begin
				add_xfer(1'(p), 8'(w * 4), ahbl_pkg::WORD, 1'b0, '0);
			end
		end
		run_transfers();
		for (int i = 0; i < N_RANDOM; i++) begin
			add_random();
		end
		run_transfers();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: flist.f
+incdir+include
design/ahbl_pkg.sv
design/bitmap_mux.sv
design/ahbl_splitter.sv
design/ahbl_sram_slave.sv
design/ahbl_fabric_top.sv
dv/ahbl_fabric_assert.sv
dv/ahbl_fabric_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the fabric testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module ahbl_fabric_tb -f flist.f -o ahbl_sim \
	&& ./obj_dir/ahbl_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qF "*** TEST FAILED ***" sim.log && exit 1
grep -qF "*** TEST PASSED ***" sim.log || exit 1
exit 0
